//--- Bender.yml
package:
  name: fft_reorder

sources:
  - cplx_pkg.sv
  - frame_pkg.sv
  - bin_wr_if.sv
  - bin_indexer.sv
  - frame_pingpong_buffer.sv
  - peak_bin_detector.sv
  - fft_reorder_top.sv
  - target: test
    files:
      - tb_fft_reorder.sv

//--- bin_indexer.sv
`timescale 1ns/1ps

module bin_indexer #(
    parameter int unsigned LOG2_N = 5
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            sample_valid_i,
    input  logic            frame_start_i,
    input  cplx_pkg::cplx_t sample_i,
    output logic            overrun_o,
    bin_wr_if.source        wr
);
    import frame_pkg::*;

    localparam int unsigned N = 1 << LOG2_N;

    logic              in_frame;
    logic [LOG2_N-1:0] pos;
    logic [LOG2_N-1:0] pos_cur;
    logic              accept;
    logic              at_last;

    assign accept  = sample_valid_i && (frame_start_i || in_frame);  // Stray samples are dropped
    assign pos_cur = frame_start_i ? '0 : pos;  // A start always restarts the count
    assign at_last = pos_cur == LOG2_N'(N - 1);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            in_frame   <= 1'b0;
            pos        <= '0;
            overrun_o  <= 1'b0;
            wr.wr_en   <= 1'b0;
            wr.wr_last <= 1'b0;
        end else begin
            overrun_o  <= sample_valid_i && frame_start_i && in_frame;  // Partial frame thrown away
            wr.wr_en   <= accept;
            wr.wr_last <= accept && at_last;
            if (accept) begin
                in_frame <= !at_last;
                pos      <= pos_cur + 1'b1;  // Wraps to zero after the last position
            end
        end
    end

    // The core emits position n for bin bitrev(n), so the address undoes that
    always_ff @(posedge clk) begin
        if (accept) begin
            wr.wr_addr <= LOG2_N'(bitrev(MAX_LOG2_N'(pos_cur), LOG2_N));
            wr.wr_data <= sample_i;
        end
    end

    // A start without its sample would be lost without a trace
    a_start_with_valid: assert property (@(posedge clk) disable iff (!rst)
        frame_start_i |-> sample_valid_i);

endmodule

//--- bin_wr_if.sv
`timescale 1ns/1ps

interface bin_wr_if #(
    parameter int unsigned LOG2_N = 5
);
    import cplx_pkg::*;

    logic              wr_en;    // One strobe per accepted sample
    logic [LOG2_N-1:0] wr_addr;  // Natural bin index of the sample
    cplx_t             wr_data;
    logic              wr_last;  // Marks position N-1 and closes the frame

    modport source (
        output wr_en,
        output wr_addr,
        output wr_data,
        output wr_last
    );

    modport sink (
        input wr_en,
        input wr_addr,
        input wr_data,
        input wr_last
    );

endinterface

//--- cplx_pkg.sv
package cplx_pkg;

    // Width of each real and imaginary part
    localparam int unsigned SAMPLE_W = 16;

    localparam int unsigned POW_W = 2 * SAMPLE_W + 1;  // Sum of two squares needs one extra bit

    // One complex FFT result, real part in the upper half
    typedef struct packed {
        logic signed [SAMPLE_W-1:0] re;
        logic signed [SAMPLE_W-1:0] im;
    } cplx_t;

    typedef logic [POW_W-1:0] pow_t;  // Unsigned re*re + im*im

endpackage

//--- fft_reorder_top.sv
`timescale 1ns/1ps

module fft_reorder_top #(
    parameter int unsigned LOG2_N = 5
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 sample_valid_i,
    input  logic                                 frame_start_i,
    input  logic signed [cplx_pkg::SAMPLE_W-1:0] sample_re_i,
    input  logic signed [cplx_pkg::SAMPLE_W-1:0] sample_im_i,
    output logic                                 bin_valid_o,
    output logic        [LOG2_N-1:0]             bin_idx_o,
    output logic signed [cplx_pkg::SAMPLE_W-1:0] bin_re_o,
    output logic signed [cplx_pkg::SAMPLE_W-1:0] bin_im_o,
    output logic                                 peak_valid_o,
    output logic        [LOG2_N-1:0]             peak_bin_o,
    output cplx_pkg::pow_t                       peak_pow_o,
    output logic                                 overrun_o
);
    import cplx_pkg::*;
    import frame_pkg::*;

    cplx_t sample_in;
    cplx_t rd_data;

    if (LOG2_N < 1 || LOG2_N > MAX_LOG2_N) begin : g_bad_len
        $error("LOG2_N outside the supported frame lengths");
    end

    assign sample_in = '{re: sample_re_i, im: sample_im_i};

    bin_wr_if #(.LOG2_N(LOG2_N)) wr_bus ();

    bin_indexer #(.LOG2_N(LOG2_N)) u_indexer (
        .clk            (clk),
        .rst            (rst),
        .sample_valid_i (sample_valid_i),
        .frame_start_i  (frame_start_i),
        .sample_i       (sample_in),
        .overrun_o      (overrun_o),
        .wr             (wr_bus.source)
    );

    frame_pingpong_buffer #(.LOG2_N(LOG2_N)) u_buffer (
        .clk        (clk),
        .rst        (rst),
        .wr         (wr_bus.sink),
        .rd_valid_o (bin_valid_o),
        .rd_bin_o   (bin_idx_o),
        .rd_data_o  (rd_data)
    );

    assign bin_re_o = rd_data.re;
    assign bin_im_o = rd_data.im;

    // The detector listens to the same natural-order stream that leaves the top
    peak_bin_detector #(.LOG2_N(LOG2_N)) u_peak (
        .clk          (clk),
        .rst          (rst),
        .bin_valid_i  (bin_valid_o),
        .bin_idx_i    (bin_idx_o),
        .bin_i        (rd_data),
        .peak_valid_o (peak_valid_o),
        .peak_bin_o   (peak_bin_o),
        .peak_pow_o   (peak_pow_o)
    );

endmodule

//--- files.f
cplx_pkg.sv
frame_pkg.sv
bin_wr_if.sv
bin_indexer.sv
frame_pingpong_buffer.sv
peak_bin_detector.sv
fft_reorder_top.sv
tb_fft_reorder.sv

//--- frame_pingpong_buffer.sv
`timescale 1ns/1ps

module frame_pingpong_buffer #(
    parameter int unsigned LOG2_N = 5
) (
    input  logic              clk,
    input  logic              rst,
    bin_wr_if.sink            wr,
    output logic              rd_valid_o,
    output logic [LOG2_N-1:0] rd_bin_o,
    output cplx_pkg::cplx_t   rd_data_o
);
    import cplx_pkg::*;

    localparam int unsigned N = 1 << LOG2_N;

    cplx_t             bank_mem [2][N];
    logic              wr_bank;    // Bank being filled by the indexer
    logic              rd_bank;    // Bank being swept out
    logic              rd_active;
    logic [LOG2_N-1:0] rd_cnt;
    logic              swap;

    assign swap = wr.wr_en && wr.wr_last;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int b = 0; b < 2; b++) begin
                for (int a = 0; a < N; a++) begin
                    bank_mem[b][a] <= '0;
                end
            end
        end else if (wr.wr_en) begin
            bank_mem[wr_bank][wr.wr_addr] <= wr.wr_data;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            wr_bank    <= 1'b0;
            rd_bank    <= 1'b0;
            rd_active  <= 1'b0;
            rd_cnt     <= '0;
            rd_valid_o <= 1'b0;
            rd_bin_o   <= '0;
            rd_data_o  <= '0;
        end else begin
            rd_valid_o <= rd_active;
            if (rd_active) begin
                rd_bin_o  <= rd_cnt;
                rd_data_o <= bank_mem[rd_bank][rd_cnt];
                rd_cnt    <= rd_cnt + 1'b1;
                if (rd_cnt == LOG2_N'(N - 1)) begin
                    rd_active <= 1'b0;
                end
            end
            // A new frame closing on the final read cycle must win, so this comes last
            if (swap) begin
                wr_bank   <= !wr_bank;
                rd_bank   <= wr_bank;  // The bank just completed
                rd_active <= 1'b1;
                rd_cnt    <= '0;
            end
        end
    end

    // Frames never shorter than N keep the indexer out of the bank under readout
    a_no_rd_clobber: assert property (@(posedge clk) disable iff (!rst)
        swap && rd_active |-> rd_cnt == LOG2_N'(N - 1));

endmodule

//--- frame_pkg.sv
package frame_pkg;

    localparam int unsigned MAX_LOG2_N = 6;  // Up to 64 points per frame

    // Mirrors the low width bits of idx, upper bits come back as zero
    function automatic logic [MAX_LOG2_N-1:0] bitrev(
        input logic [MAX_LOG2_N-1:0] idx,
        input int unsigned           width
    );
        logic [MAX_LOG2_N-1:0] rev;
        rev = '0;
        for (int i = 0; i < MAX_LOG2_N; i++) begin
            if (i < width) begin
                rev[i] = idx[width-1-i];
            end
        end
        return rev;
    endfunction

endpackage

//--- peak_bin_detector.sv
`timescale 1ns/1ps

module peak_bin_detector #(
    parameter int unsigned LOG2_N = 5
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              bin_valid_i,
    input  logic [LOG2_N-1:0] bin_idx_i,
    input  cplx_pkg::cplx_t   bin_i,
    output logic              peak_valid_o,
    output logic [LOG2_N-1:0] peak_bin_o,
    output cplx_pkg::pow_t    peak_pow_o
);
    import cplx_pkg::*;

    localparam int unsigned N = 1 << LOG2_N;

    logic signed [2*SAMPLE_W-1:0] sq_re;
    logic signed [2*SAMPLE_W-1:0] sq_im;
    logic                         p_valid;
    logic                         p_last;
    logic [LOG2_N-1:0]            p_bin;
    pow_t                         p_pow;
    pow_t                         max_pow;
    logic [LOG2_N-1:0]            max_bin;
    logic                         take;
    pow_t                         best_pow;
    logic [LOG2_N-1:0]            best_bin;

    assign sq_re = bin_i.re * bin_i.re;
    assign sq_im = bin_i.im * bin_i.im;

    assign take     = p_pow > max_pow;  // Strictly greater, so the lower bin keeps a tie
    assign best_pow = take ? p_pow : max_pow;
    assign best_bin = take ? p_bin : max_bin;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            p_valid      <= 1'b0;
            p_last       <= 1'b0;
            p_bin        <= '0;
            max_pow      <= '0;
            max_bin      <= '0;
            peak_valid_o <= 1'b0;
            peak_bin_o   <= '0;
            peak_pow_o   <= '0;
        end else begin
            p_valid      <= bin_valid_i;
            p_last       <= bin_valid_i && bin_idx_i == LOG2_N'(N - 1);
            p_bin        <= bin_idx_i;
            peak_valid_o <= p_valid && p_last;
            if (p_valid && p_last) begin
                peak_bin_o <= best_bin;
                peak_pow_o <= best_pow;
                max_pow    <= '0;  // Ready for bin 0 of the next frame
                max_bin    <= '0;
            end else if (p_valid) begin
                max_pow <= best_pow;
                max_bin <= best_bin;
            end
        end
    end

    always_ff @(posedge clk) begin
        p_pow <= pow_t'(sq_re) + pow_t'(sq_im);
    end

    // Readout from the buffer is a gapless ascending sweep
    a_bin_order: assert property (@(posedge clk) disable iff (!rst)
        bin_valid_i && bin_idx_i != LOG2_N'(N - 1)
            |=> bin_valid_i && bin_idx_i == LOG2_N'($past(bin_idx_i) + 1'b1));

endmodule

//--- tb_fft_reorder.sv
`timescale 1ns/1ps

module tb_fft_reorder;
    import cplx_pkg::*;

    localparam int LOG2_N = 5;
    localparam int N = 1 << LOG2_N;
    localparam int MAX_GAP = 16;  // Idle cycles allowed inside one frame
    localparam int FRAME_SLOTS = 24;  // Frames, drains and idle windows of all tests
    localparam int TIMEOUT = FRAME_SLOTS * (N + MAX_GAP) + 200;
    localparam int TIE_LO = N / 4 + 1;
    localparam int TIE_HI = N - 3;
    localparam logic [31:0] SEED = 32'h9f64_8dd7;

    logic clk;
    logic rst;
    logic sample_valid_i;
    logic frame_start_i;
    logic signed [SAMPLE_W-1:0] sample_re_i;
    logic signed [SAMPLE_W-1:0] sample_im_i;
    logic bin_valid_o;
    logic [LOG2_N-1:0] bin_idx_o;
    logic signed [SAMPLE_W-1:0] bin_re_o;
    logic signed [SAMPLE_W-1:0] bin_im_o;
    logic peak_valid_o;
    logic [LOG2_N-1:0] peak_bin_o;
    pow_t peak_pow_o;
    logic overrun_o;

    cplx_t stim [N];
    cplx_t ref_pos [N];
    cplx_t ref_bins [N];
    cplx_t act_bin;
    pow_t ref_peak_pow;
    logic [LOG2_N-1:0] ref_peak_bin;
    cplx_t exp_samples [$];
    int exp_last_cycle [$];
    logic [LOG2_N-1:0] exp_pk_bin [$];
    pow_t exp_pk_pow [$];
    int exp_pk_cycle [$];
    int cycle = 0;
    int first_cycle, frames_pending, overrun_count, overrun_cycle, ovr_before;
    int checks, errors, test_checks, test_errors, tests_run, tests_failed;
    int rd_idx;
    bit in_readout;
    string test_name;

    fft_reorder_top #(.LOG2_N(LOG2_N)) uut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    function automatic int reverse_bits(input int idx, input int width);
        int r;
        r = 0;
        for (int i = 0; i < width; i++) r = (r << 1) | ((idx >> i) & 1);
        return r;
    endfunction

    function automatic pow_t bin_power(input cplx_t c);
        longint p;
        p = longint'(c.re) * longint'(c.re) + longint'(c.im) * longint'(c.im);
        return pow_t'(p);
    endfunction

    // Core position n carries bin bitrev(n); only a strictly larger power moves the peak
    function automatic void expected_frame();
        pow_t p;
        for (int n = 0; n < N; n++) ref_bins[reverse_bits(n, LOG2_N)] = ref_pos[n];
        ref_peak_bin = '0;
        ref_peak_pow = bin_power(ref_bins[0]);
        for (int b = 1; b < N; b++) begin
            p = bin_power(ref_bins[b]);
            if (p > ref_peak_pow) begin
                ref_peak_pow = p;
                ref_peak_bin = LOG2_N'(b);
            end
        end
    endfunction

    function automatic cplx_t rand_sample();
        cplx_t c;
        c.re = SAMPLE_W'($urandom);
        c.im = SAMPLE_W'($urandom);
        return c;
    endfunction

    task automatic start_test(input string name);
        test_name = name;
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic finish_test();
        tests_run++;
        if (test_errors != 0) tests_failed++;
        $display("test %s: %0d checks, %0d errors", test_name, test_checks, test_errors);
    endtask

    task automatic report_failure(input string msg);
        errors++;
        test_errors++;
        $display("[ERROR] %s: %s", test_name, msg);
    endtask

    task automatic check_bin(input int bin, input cplx_t exp_v, input cplx_t act_v);
        checks++;
        test_checks++;
        if (exp_v !== act_v) begin
            errors++;
            test_errors++;
            $display("[ERROR] %s: bin %0d expected re=%0d im=%0d, actual re=%0d im=%0d",
                     test_name, bin, exp_v.re, exp_v.im, act_v.re, act_v.im);
        end
    endtask

    task automatic check_peak(input logic [LOG2_N-1:0] exp_b, input pow_t exp_p,
                              input logic [LOG2_N-1:0] act_b, input pow_t act_p);
        checks++;
        test_checks++;
        if (exp_b !== act_b || exp_p !== act_p) begin
            errors++;
            test_errors++;
            $display("[ERROR] %s: peak expected bin %0d pow %0d, actual bin %0d pow %0d",
                     test_name, exp_b, exp_p, act_b, act_p);
        end
    endtask

    task automatic drive_gap(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            #1;
            sample_valid_i = 1'b0;
            frame_start_i = 1'b0;
            {sample_re_i, sample_im_i} = rand_sample();  // Junk that must be ignored
        end
    endtask

    // Samples that never complete a frame, so nothing is queued for them
    task automatic drive_samples(input int count, input bit with_start);
        for (int n = 0; n < count; n++) begin
            @(posedge clk);
            #1;
            sample_valid_i = 1'b1;
            frame_start_i = with_start && (n == 0);
            {sample_re_i, sample_im_i} = rand_sample();
        end
    endtask

    task automatic drive_frame(input int max_gap);
        int budget;
        int gap;
        budget = max_gap;
        for (int n = 0; n < N; n++) begin
            @(posedge clk);
            #1;
            sample_valid_i = 1'b1;
            frame_start_i = (n == 0);
            {sample_re_i, sample_im_i} = stim[n];
            if (n == 0) first_cycle = cycle;
            if (n < N - 1 && budget > 0 && $urandom_range(3) == 0) begin
                gap = 1 + $urandom_range(2);
                if (gap > budget) gap = budget;
                budget -= gap;
                drive_gap(gap);
            end
        end
        for (int n = 0; n < N; n++) exp_samples.push_back(stim[n]);
        exp_last_cycle.push_back(cycle);
        frames_pending++;
    endtask

    task automatic drain();
        drive_gap(1);
        while (frames_pending > 0) drive_gap(1);
        drive_gap(4);
    endtask

    task automatic fill_random();
        for (int n = 0; n < N; n++) stim[n] = rand_sample();
    endtask

    // Small noise with two equal maxima at bins TIE_LO and TIE_HI
    task automatic fill_tie();
        int v;
        for (int n = 0; n < N; n++) begin
            v = $urandom_range(200) - 100;
            stim[n].re = SAMPLE_W'(v);
            v = $urandom_range(200) - 100;
            stim[n].im = SAMPLE_W'(v);
        end
        stim[reverse_bits(TIE_LO, LOG2_N)] = '{re: 16'sd1200, im: -16'sd700};
        stim[reverse_bits(TIE_HI, LOG2_N)] = '{re: -16'sd700, im: 16'sd1200};
    endtask

    always @(negedge clk) begin
        if (rst) begin
            if (bin_valid_o && !in_readout) begin
                if (bin_idx_o != '0 || exp_last_cycle.size() == 0) begin
                    report_failure("bin output appeared with no complete frame pending");
                end else begin
                    for (int n = 0; n < N; n++) ref_pos[n] = exp_samples.pop_front();
                    expected_frame();
                    checks++;
                    if (cycle != exp_last_cycle.pop_front() + 3)
                        report_failure("bin 0 did not follow the last sample by 3 cycles");
                    in_readout = 1'b1;
                    rd_idx = 0;
                end
            end
            if (bin_valid_o && in_readout) begin
                checks++;
                if (int'(bin_idx_o) != rd_idx) report_failure("bin index out of natural order");
                act_bin = '{re: bin_re_o, im: bin_im_o};
                check_bin(rd_idx, ref_bins[rd_idx], act_bin);
                rd_idx++;
                if (rd_idx == N) begin
                    in_readout = 1'b0;
                    exp_pk_bin.push_back(ref_peak_bin);
                    exp_pk_pow.push_back(ref_peak_pow);
                    exp_pk_cycle.push_back(cycle + 2);
                end
            end else if (in_readout) begin
                report_failure("bin stream stopped before the last bin");
                in_readout = 1'b0;
            end
            if (peak_valid_o) begin
                if (exp_pk_bin.size() == 0) begin
                    report_failure("peak reported with no frame read out");
                end else begin
                    checks++;
                    if (cycle != exp_pk_cycle.pop_front())
                        report_failure("peak_valid_o not 2 cycles after the last bin");
                    check_peak(exp_pk_bin.pop_front(), exp_pk_pow.pop_front(),
                               peak_bin_o, peak_pow_o);
                    frames_pending--;
                end
            end
            if (overrun_o) begin
                overrun_count++;
                overrun_cycle = cycle;
            end
        end
    end

    initial begin
        while (cycle < TIMEOUT) @(posedge clk);
        $display("Run stopped at cycle %0d with %0d frames still pending", cycle, frames_pending);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        rst = 1'b0;
        sample_valid_i = 1'b0;
        frame_start_i = 1'b0;
        sample_re_i = '0;
        sample_im_i = '0;
        void'($urandom(SEED));
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b1;

        start_test("stray_after_reset");
        checks++;
        if (bin_valid_o || peak_valid_o || overrun_o) report_failure("outputs active after reset");
        drive_samples(N + 8, 1'b0);  // More than a frame, so accepted strays would close one
        drive_gap(2 * N);  // Observation window, nothing may come out
        finish_test();

        start_test("back_to_back");
        repeat (4) begin
            fill_random();
            drive_frame(0);
        end
        drain();
        finish_test();

        start_test("random_gaps");
        repeat (4) begin
            fill_random();
            drive_frame(MAX_GAP);
        end
        drain();
        finish_test();

        start_test("peak_tie");
        fill_tie();
        drive_frame(0);
        for (int n = 0; n < N; n++) stim[n] = '0;
        drive_frame(0);
        drain();
        finish_test();

        start_test("overrun");
        ovr_before = overrun_count;
        drive_samples(N / 2, 1'b1);
        fill_random();
        drive_frame(0);
        drain();
        checks++;
        if (overrun_count != ovr_before + 1)
            report_failure("overrun_o did not pulse once for the restarted frame");
        else if (overrun_cycle != first_cycle + 1)
            report_failure("overrun_o pulse not 1 cycle after the restarting start");
        finish_test();

        start_test("stray_no_frame");
        drive_samples(N + 8, 1'b0);
        drive_gap(2 * N);
        checks++;
        if (overrun_count != 1) report_failure("overrun_o pulsed outside the overrun test");
        finish_test();

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
